/* sim.f */
source/pad_pkg.sv
source/padring.sv
source/jtag_mux.sv
source/pad_ctrl.sv
source/pad_top.sv
tb/pad_top_asserts.sv
tb/tb_pad_top.sv

/* Makefile */
# Verilator build and run for the pad ring
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_pad_top
FILELIST := sim.f
BUILD    := obj_dir
LOG      := sim.log
PASS_MSG := === PASS ===

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the simulation, then search $(LOG) for the pass line"
	@echo "  clean  remove build output and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "Simulation failed"; exit 1)
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD) $(LOG)

/* tb/tb_pad_top.sv */
// Testbench for the pad ring top level
// Config port master, register mirror, reference model and output checker
module tb_pad_top;

  import pad_pkg::*;

  localparam int Timeout = 20; // Cycles allowed per handshake phase

  logic               clk;
  logic               rst_n;
  logic               cfg_req;
  cfg_op_e            cfg_op;
  logic [CfgAw-1:0]   cfg_addr;
  logic [CfgDw-1:0]   cfg_wdata;
  logic               cfg_ack;
  logic [CfgDw-1:0]   cfg_rdata;
  logic [NumPads-1:0] pad_in;
  logic [NumPads-1:0] pad_out;
  logic [NumPads-1:0] pad_oe;
  logic [NumPads-1:0] pad_pu;
  logic               jtag_tdo;
  logic               jtag_tck;
  logic               jtag_tms;
  logic               jtag_tdi;
  logic               jtag_trst_n;

  // Register mirror
  logic [NumPads-1:0] out_m;
  logic [NumPads-1:0] oe_m;
  logic [AttrDw-1:0]  attr_m [NumPads];
  logic               txn_open;
  logic [27:0]        exp_pads;
  integer             seed;

  pad_top i_dut (
    .clk_i         ( clk         ),
    .rst_n_i       ( rst_n       ),
    .cfg_req_i     ( cfg_req     ),
    .cfg_op_i      ( cfg_op      ),
    .cfg_addr_i    ( cfg_addr    ),
    .cfg_wdata_i   ( cfg_wdata   ),
    .cfg_ack_o     ( cfg_ack     ),
    .cfg_rdata_o   ( cfg_rdata   ),
    .pad_in_i      ( pad_in      ),
    .pad_out_o     ( pad_out     ),
    .pad_oe_o      ( pad_oe      ),
    .pad_pu_o      ( pad_pu      ),
    .jtag_tdo_i    ( jtag_tdo    ),
    .jtag_tck_o    ( jtag_tck    ),
    .jtag_tms_o    ( jtag_tms    ),
    .jtag_tdi_o    ( jtag_tdi    ),
    .jtag_trst_n_o ( jtag_trst_n )
  );

  always #50 clk = ~clk;

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Expected {pad_out, pad_oe, pad_pu, tck, tms, tdi, trst_n}
  function automatic logic [27:0] ref_pads();
    logic [NumPads-1:0] inv;
    logic [NumPads-1:0] ring_out;
    logic [NumPads-1:0] ring_oe;
    logic [NumPads-1:0] exp_out;
    logic [NumPads-1:0] exp_oe;
    logic [NumPads-1:0] exp_pu;
    logic [3:0]         jtag;
    logic               eff;
    for (int i = 0; i < NumPads; i++) begin
      inv[i]    = attr_m[i][AttrInvIdx];
      exp_pu[i] = attr_m[i][AttrPuIdx];
    end
    ring_out = out_m;
    ring_oe  = oe_m;
    jtag     = 4'b0000; // Debug port idle and in reset
    if (pad_in[JtagEnIdx] ^ inv[JtagEnIdx]) begin
      jtag = {pad_in[TckIdx] ^ inv[TckIdx], pad_in[TmsIdx] ^ inv[TmsIdx],
              pad_in[TdiIdx] ^ inv[TdiIdx], 1'b1};
      ring_out[TdiIdx:TckIdx] = '0;
      ring_oe[TdiIdx:TckIdx]  = '0;
      ring_out[TdoIdx]        = jtag_tdo;
      ring_oe[TdoIdx]         = 1'b1;
    end
    for (int i = 0; i < NumPads; i++) begin
      eff = ring_out[i] ^ inv[i];
      if (attr_m[i][AttrOdIdx]) begin
        exp_out[i] = 1'b0; // Open-drain only pulls low
        exp_oe[i]  = ring_oe[i] & ~eff;
      end else begin
        exp_out[i] = eff;
        exp_oe[i]  = ring_oe[i];
      end
    end
    return {exp_out, exp_oe, exp_pu, jtag};
  endfunction

  function automatic logic [CfgDw-1:0] ref_rdata(logic [CfgAw-1:0] addr);
    logic [NumPads-1:0] core_in;
    for (int i = 0; i < NumPads; i++) begin
      core_in[i] = pad_in[i] ^ attr_m[i][AttrInvIdx];
    end
    if (core_in[JtagEnIdx]) begin
      for (int i = TckIdx; i <= TdoIdx; i++) begin
        core_in[i] = TieOffValues[i];
      end
    end
    if (addr[3]) begin
      return CfgDw'(attr_m[addr[2:0]]);
    end else if (addr == RegOut) begin
      return out_m;
    end else if (addr == RegOe) begin
      return oe_m;
    end else if (addr == RegIn) begin
      return core_in;
    end else begin
      return '0; // Unmapped hole
    end
  endfunction

  //////////////////////////////
  // Checking
  //////////////////////////////

  task automatic check_value(string what, logic [CfgDw-1:0] got, logic [CfgDw-1:0] exp);
    if (got !== exp) begin
      $display("ERR %0t: %s is %0h, expected %0h", $time, what, got, exp);
      $display("=== FAIL ===");
      $fatal(1, "Mismatch on %s", what);
    end
  endtask

  // Outputs are compared only between transfers
  always @(negedge clk) begin
    if (rst_n && !txn_open) begin
      exp_pads = ref_pads();
      check_value("pad_out_o", pad_out, exp_pads[27:20]);
      check_value("pad_oe_o", pad_oe, exp_pads[19:12]);
      check_value("pad_pu_o", pad_pu, exp_pads[11:4]);
      check_value("jtag {tck,tms,tdi,trst_n}",
                  CfgDw'({jtag_tck, jtag_tms, jtag_tdi, jtag_trst_n}), CfgDw'(exp_pads[3:0]));
      check_value("cfg_ack_o while idle", CfgDw'(cfg_ack), '0);
    end
  end

  //////////////////////////////
  // Config port master
  //////////////////////////////

  task automatic transfer(cfg_op_e op, logic [CfgAw-1:0] addr, logic [CfgDw-1:0] wdata,
                          output logic [CfgDw-1:0] rdata);
    int n;
    @(posedge clk);
    txn_open  = 1'b1;
    cfg_req   <= 1'b1;
    cfg_op    <= op;
    cfg_addr  <= addr;
    cfg_wdata <= wdata;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!cfg_ack && n < Timeout);
    if (!cfg_ack) begin
      $display("Config handshake stuck, ack never rose for address %0d", addr);
      $display("=== FAIL ===");
      $fatal(1, "Handshake timeout");
    end
    rdata = cfg_rdata; // Valid while ack is high
    @(posedge clk);
    cfg_req <= 1'b0;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (cfg_ack && n < Timeout);
    if (cfg_ack) begin
      $display("Config handshake stuck, ack never fell for address %0d", addr);
      $display("=== FAIL ===");
      $fatal(1, "Handshake timeout");
    end
    txn_open = 1'b0;
  endtask

  task automatic cfg_write(logic [CfgAw-1:0] addr, logic [CfgDw-1:0] data);
    logic [CfgDw-1:0] unused;
    transfer(OpWrite, addr, data, unused);
    if (addr == RegOut) begin
      out_m = data;
    end else if (addr == RegOe) begin
      oe_m = data;
    end else if (addr[3]) begin
      attr_m[addr[2:0]] = data[AttrDw-1:0];
    end
  endtask

  task automatic cfg_read(logic [CfgAw-1:0] addr);
    logic [CfgDw-1:0] exp;
    logic [CfgDw-1:0] got;
    exp = ref_rdata(addr);
    transfer(OpRead, addr, '0, got);
    check_value($sformatf("read of address %0d", addr), got, exp);
  endtask

  // Drive pads, then let the synchronizer settle
  task automatic set_pads(logic [NumPads-1:0] value, logic tdo);
    @(posedge clk);
    pad_in   <= value;
    jtag_tdo <= tdo;
    repeat (3) @(posedge clk);
  endtask

  task automatic randomize_regs();
    logic [CfgDw-1:0] val;
    cfg_write(RegOut, CfgDw'($random(seed)));
    cfg_write(RegOe, CfgDw'($random(seed)));
    for (int a = RegAttr0; a <= RegAttr7; a++) begin
      val = CfgDw'($random(seed));
      if (a == RegAttr7) begin
        val[AttrInvIdx] = 1'b0; // Keep the strap pad uninverted
      end
      cfg_write(CfgAw'(a), val);
    end
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    cfg_req   = 1'b0;
    cfg_op    = OpRead;
    cfg_addr  = '0;
    cfg_wdata = '0;
    pad_in    = '0;
    jtag_tdo  = 1'b0;
    txn_open  = 1'b0;
    out_m     = '0;
    oe_m      = '0;
    seed      = 32'h45ea;
    for (int i = 0; i < NumPads; i++) begin
      attr_m[i] = '0;
    end
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;

    // Everything reads back as zero after reset
    cfg_read(RegOut);
    cfg_read(RegOe);
    for (int a = RegAttr0; a <= RegAttr7; a++) begin
      cfg_read(CfgAw'(a));
    end

    // Register access
    repeat (4) begin
      randomize_regs();
      cfg_read(RegOut);
      cfg_read(RegOe);
      for (int a = RegAttr0; a <= RegAttr7; a++) begin
        cfg_read(CfgAw'(a));
      end
    end
    cfg_write(RegIn, CfgDw'($random(seed))); // Read-only, mirror untouched
    cfg_read(RegIn);
    for (int a = 3; a < 8; a++) begin
      cfg_read(CfgAw'(a));
    end

    // JTAG off, pad outputs and synchronized inputs
    repeat (6) begin
      randomize_regs();
      set_pads(NumPads'($random(seed)) & 8'h7f, 1'($random(seed)));
      cfg_read(RegIn);
    end

    // JTAG overlay on
    repeat (6) begin
      randomize_regs();
      set_pads(NumPads'($random(seed)) | 8'h80, 1'($random(seed)));
      cfg_read(RegIn);
      set_pads(pad_in, ~jtag_tdo); // TDO toggles through pad 6
    end

    // Strap dropped, back to pass-through
    set_pads(NumPads'($random(seed)) & 8'h7f, 1'b1);
    cfg_read(RegIn);
    randomize_regs();
    repeat (2) @(posedge clk);

    $display("=== PASS ===");
    $finish;
  end

endmodule : tb_pad_top

/* tb/pad_top_asserts.sv */
// Pad ring assertions
// Config handshake and pad rule checks bound into the top level
module pad_top_asserts (
  input logic                                             clk_i,
  input logic                                             rst_n_i,
  input logic                                             cfg_req_i,
  input logic                                             cfg_ack_i,
  input logic [pad_pkg::NumPads-1:0]                      pad_in_i,
  input logic [pad_pkg::NumPads-1:0]                      pad_out_i,
  input logic                                             jtag_trst_n_i,
  input logic [pad_pkg::NumPads-1:0][pad_pkg::AttrDw-1:0] attr_i
);

  import pad_pkg::*;

  logic [NumPads-1:0] od_mask;

  always_comb begin
    for (int i = 0; i < NumPads; i++) begin
      od_mask[i] = attr_i[i][AttrOdIdx];
    end
  end

  ack_rise_with_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(cfg_ack_i) |-> cfg_req_i)
    else $error("cfg ack rose while request was low");

  ack_fall_after_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $fell(cfg_ack_i) |-> !cfg_req_i)
    else $error("cfg ack fell while request was still high");

  trst_held_when_off: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !pad_in_i[JtagEnIdx] |-> !jtag_trst_n_i)
    else $error("debug port out of reset with JTAG strap low");

  od_never_high: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (pad_out_i & od_mask) == '0)
    else $error("open-drain pad drives a high output");

endmodule : pad_top_asserts

bind pad_top pad_top_asserts i_asserts (
  .clk_i         ( clk_i         ),
  .rst_n_i       ( rst_n_i       ),
  .cfg_req_i     ( cfg_req_i     ),
  .cfg_ack_i     ( cfg_ack_o     ),
  .pad_in_i      ( pad_in_i      ),
  .pad_out_i     ( pad_out_o     ),
  .jtag_trst_n_i ( jtag_trst_n_o ),
  .attr_i        ( attr          )
);

/* source/pad_top.sv */
// Pad ring top level
// Control block, JTAG overlay mux and pad ring model wired together
module pad_top (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  // Config port
  input  logic                        cfg_req_i,
  input  pad_pkg::cfg_op_e            cfg_op_i,
  input  logic [pad_pkg::CfgAw-1:0]   cfg_addr_i,
  input  logic [pad_pkg::CfgDw-1:0]   cfg_wdata_i,
  output logic                        cfg_ack_o,
  output logic [pad_pkg::CfgDw-1:0]   cfg_rdata_o,
  // Pads
  input  logic [pad_pkg::NumPads-1:0] pad_in_i,
  output logic [pad_pkg::NumPads-1:0] pad_out_o,
  output logic [pad_pkg::NumPads-1:0] pad_oe_o,
  output logic [pad_pkg::NumPads-1:0] pad_pu_o,
  // Debug port
  input  logic                        jtag_tdo_i,
  output logic                        jtag_tck_o,
  output logic                        jtag_tms_o,
  output logic                        jtag_tdi_o,
  output logic                        jtag_trst_n_o
);

  import pad_pkg::*;

  logic [NumPads-1:0]             out_core, oe_core, in_core;
  logic [NumPads-1:0]             out_padring, oe_padring, in_padring;
  logic [NumPads-1:0][AttrDw-1:0] attr;

  //////////////////////////////
  // Core side
  //////////////////////////////

  pad_ctrl i_pad_ctrl (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .cfg_req_i   ( cfg_req_i   ),
    .cfg_op_i    ( cfg_op_i    ),
    .cfg_addr_i  ( cfg_addr_i  ),
    .cfg_wdata_i ( cfg_wdata_i ),
    .cfg_ack_o   ( cfg_ack_o   ),
    .cfg_rdata_o ( cfg_rdata_o ),
    .in_core_i   ( in_core     ),
    .out_core_o  ( out_core    ),
    .oe_core_o   ( oe_core     ),
    .attr_o      ( attr        )  // Straight to padring, no overlay
  );

  //////////////////////////////
  // Overlay and pads
  //////////////////////////////

  jtag_mux i_jtag_mux (
    .out_core_i    ( out_core      ),
    .oe_core_i     ( oe_core       ),
    .in_core_o     ( in_core       ),
    .out_padring_o ( out_padring   ),
    .oe_padring_o  ( oe_padring    ),
    .in_padring_i  ( in_padring    ),
    .jtag_tdo_i    ( jtag_tdo_i    ),
    .jtag_tck_o    ( jtag_tck_o    ),
    .jtag_tms_o    ( jtag_tms_o    ),
    .jtag_tdi_o    ( jtag_tdi_o    ),
    .jtag_trst_n_o ( jtag_trst_n_o )
  );

  padring i_padring (
    .out_i     ( out_padring ),
    .oe_i      ( oe_padring  ),
    .attr_i    ( attr        ),
    .pad_in_i  ( pad_in_i    ),
    .in_o      ( in_padring  ),
    .pad_out_o ( pad_out_o   ),
    .pad_oe_o  ( pad_oe_o    ),
    .pad_pu_o  ( pad_pu_o    )
  );

endmodule : pad_top

/* source/pad_ctrl.sv */
// Pad control block
// Four-phase config slave holding pad output, enable and attribute
// registers, plus a 2-flop synchronizer on the pad inputs
module pad_ctrl (
  input  logic                                             clk_i,
  input  logic                                             rst_n_i,
  // Config port
  input  logic                                             cfg_req_i,
  input  pad_pkg::cfg_op_e                                 cfg_op_i,
  input  logic [pad_pkg::CfgAw-1:0]                        cfg_addr_i,
  input  logic [pad_pkg::CfgDw-1:0]                        cfg_wdata_i,
  output logic                                             cfg_ack_o,
  output logic [pad_pkg::CfgDw-1:0]                        cfg_rdata_o,
  // Core-side pad signals
  input  logic [pad_pkg::NumPads-1:0]                      in_core_i,
  output logic [pad_pkg::NumPads-1:0]                      out_core_o,
  output logic [pad_pkg::NumPads-1:0]                      oe_core_o,
  output logic [pad_pkg::NumPads-1:0][pad_pkg::AttrDw-1:0] attr_o
);

  import pad_pkg::*;

  logic                            ack_q;
  logic                            start;
  cfg_reg_e                        reg_sel;
  logic [$clog2(NumPads)-1:0]      attr_idx;
  logic [CfgDw-1:0]                rdata_d;
  logic [CfgDw-1:0]                rdata_q;
  logic [NumPads-1:0]              out_q;
  logic [NumPads-1:0]              oe_q;
  logic [NumPads-1:0][AttrDw-1:0]  attr_q;
  logic [NumPads-1:0]              in_meta_q;
  logic [NumPads-1:0]              in_sync_q;

  //////////////////////////////
  // Handshake
  //////////////////////////////

  assign start    = cfg_req_i & ~ack_q; // New request, not yet acked
  assign reg_sel  = cfg_reg_e'(cfg_addr_i);
  assign attr_idx = cfg_addr_i[$clog2(NumPads)-1:0]; // Pad number for RegAttrN

  // Ack follows req one edge later, held as long as req stays up
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= cfg_req_i;
    end
  end

  //////////////////////////////
  // Registers
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      out_q  <= '0;
      oe_q   <= '0;
      attr_q <= '0;
    end else if (start && cfg_op_i == OpWrite) begin
      case (reg_sel)
        RegOut: out_q <= cfg_wdata_i;
        RegOe:  oe_q  <= cfg_wdata_i;
        RegAttr0, RegAttr1, RegAttr2, RegAttr3,
        RegAttr4, RegAttr5, RegAttr6, RegAttr7: begin
          attr_q[attr_idx] <= cfg_wdata_i[AttrDw-1:0];
        end
        default: ; // RegIn and holes are not writable
      endcase
    end
  end

  // Read mux, unmapped addresses give 0
  always_comb begin
    case (reg_sel)
      RegOut:  rdata_d = out_q;
      RegOe:   rdata_d = oe_q;
      RegIn:   rdata_d = in_sync_q;
      RegAttr0, RegAttr1, RegAttr2, RegAttr3,
      RegAttr4, RegAttr5, RegAttr6, RegAttr7: begin
        rdata_d = CfgDw'(attr_q[attr_idx]);
      end
      default: rdata_d = '0;
    endcase
  end

  // Captured with ack so it stays valid after addr is released
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rdata_q <= '0;
    end else if (start && cfg_op_i == OpRead) begin
      rdata_q <= rdata_d;
    end
  end

  // Pad input synchronizer
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      in_meta_q <= '0;
      in_sync_q <= '0;
    end else begin
      in_meta_q <= in_core_i;
      in_sync_q <= in_meta_q;
    end
  end

  assign cfg_ack_o   = ack_q;
  assign cfg_rdata_o = rdata_q;
  assign out_core_o  = out_q;
  assign oe_core_o   = oe_q;
  assign attr_o      = attr_q;

endmodule : pad_ctrl

/* source/jtag_mux.sv */
// JTAG overlay mux
// Hands four pads to the debug port while the strap pad selects JTAG,
// all other pads pass straight through
module jtag_mux (
  // Core side
  input  logic [pad_pkg::NumPads-1:0] out_core_i,
  input  logic [pad_pkg::NumPads-1:0] oe_core_i,
  output logic [pad_pkg::NumPads-1:0] in_core_o,
  // Padring side
  output logic [pad_pkg::NumPads-1:0] out_padring_o,
  output logic [pad_pkg::NumPads-1:0] oe_padring_o,
  input  logic [pad_pkg::NumPads-1:0] in_padring_i,
  // Debug port
  input  logic                        jtag_tdo_i,
  output logic                        jtag_tck_o,
  output logic                        jtag_tms_o,
  output logic                        jtag_tdi_o,
  output logic                        jtag_trst_n_o
);

  import pad_pkg::*;

  logic jtag_en;

  assign jtag_en = in_padring_i[JtagEnIdx]; // Active high strap

  always_comb begin
    // Default is plain pass-through
    out_padring_o = out_core_i;
    oe_padring_o  = oe_core_i;
    in_core_o     = in_padring_i;
    jtag_tck_o    = 1'b0;
    jtag_tms_o    = 1'b0;
    jtag_tdi_o    = 1'b0;
    jtag_trst_n_o = 1'b0; // Debug port held in reset

    if (jtag_en) begin
      // Inputs toward the debug port
      jtag_tck_o = in_padring_i[TckIdx];
      jtag_tms_o = in_padring_i[TmsIdx];
      jtag_tdi_o = in_padring_i[TdiIdx];

      out_padring_o[TckIdx] = 1'b0;
      out_padring_o[TmsIdx] = 1'b0;
      out_padring_o[TdiIdx] = 1'b0;
      oe_padring_o[TckIdx]  = 1'b0;
      oe_padring_o[TmsIdx]  = 1'b0;
      oe_padring_o[TdiIdx]  = 1'b0;

      // TDO driven by the debug port
      out_padring_o[TdoIdx] = jtag_tdo_i;
      oe_padring_o[TdoIdx]  = 1'b1;

      // Core no longer sees these pads
      in_core_o[TckIdx] = TieOffValues[TckIdx];
      in_core_o[TmsIdx] = TieOffValues[TmsIdx];
      in_core_o[TdiIdx] = TieOffValues[TdiIdx];
      in_core_o[TdoIdx] = TieOffValues[TdoIdx];

      jtag_trst_n_o = 1'b1;
    end
  end

endmodule : jtag_mux

/* source/padring.sv */
// Pad ring model
// Applies invert, open-drain and pull-up attributes between core-side
// signals and the split pad pins
module padring (
  input  logic [pad_pkg::NumPads-1:0]                      out_i,
  input  logic [pad_pkg::NumPads-1:0]                      oe_i,
  input  logic [pad_pkg::NumPads-1:0][pad_pkg::AttrDw-1:0] attr_i,
  input  logic [pad_pkg::NumPads-1:0]                      pad_in_i,
  output logic [pad_pkg::NumPads-1:0]                      in_o,
  output logic [pad_pkg::NumPads-1:0]                      pad_out_o,
  output logic [pad_pkg::NumPads-1:0]                      pad_oe_o,
  output logic [pad_pkg::NumPads-1:0]                      pad_pu_o
);

  import pad_pkg::*;

  //////////////////////////////
  // Per-pad attribute logic
  //////////////////////////////

  for (genvar i = 0; i < NumPads; i++) begin : g_pad
    logic inv;
    logic od;
    logic out_eff;

    assign inv     = attr_i[i][AttrInvIdx];
    assign od      = attr_i[i][AttrOdIdx];
    assign out_eff = out_i[i] ^ inv; // Polarity after invert

    // Open-drain never drives high, a high output turns the driver off
    assign pad_out_o[i] = od ? 1'b0 : out_eff;
    assign pad_oe_o[i]  = od ? (oe_i[i] & ~out_eff) : oe_i[i];

    assign pad_pu_o[i] = attr_i[i][AttrPuIdx];

    // Input path sees the same invert
    assign in_o[i] = pad_in_i[i] ^ inv;
  end

endmodule : padring

/* source/pad_pkg.sv */
// Pad ring shared definitions
// Pad map, attribute layout, JTAG overlay map and config port encodings
package pad_pkg;

  //////////////////////////////
  // Pads and attributes
  //////////////////////////////

  localparam int NumPads = 8;

  // Attribute bits per pad
  localparam int AttrDw     = 3;
  localparam int AttrInvIdx = 0; // Invert both directions
  localparam int AttrPuIdx  = 1; // Pull-up enable
  localparam int AttrOdIdx  = 2; // Open-drain, pad only pulls low

  //////////////////////////////
  // Config port
  //////////////////////////////

  localparam int CfgAw = 4;
  localparam int CfgDw = 8; // One bit per pad

  //////////////////////////////
  // JTAG overlay
  //////////////////////////////

  localparam int TckIdx    = 3;
  localparam int TmsIdx    = 4;
  localparam int TdiIdx    = 5;
  localparam int TdoIdx    = 6;
  localparam int JtagEnIdx = 7; // Strap pad, high selects JTAG

  // Seen by the core on overlaid pads while JTAG owns them.
  // TMS pad doubles as an active-low select, so it idles high.
  localparam logic [NumPads-1:0] TieOffValues = NumPads'(1 << TmsIdx);

  // Transfer direction
  typedef enum logic {
    OpRead  = 1'b0,
    OpWrite = 1'b1
  } cfg_op_e;

  // Register map
  typedef enum logic [CfgAw-1:0] {
    RegOut   = 4'd0,  // Core output bits
    RegOe    = 4'd1,  // Core output enables
    RegIn    = 4'd2,  // Synchronized pad inputs, read-only
    RegAttr0 = 4'd8,
    RegAttr1 = 4'd9,
    RegAttr2 = 4'd10,
    RegAttr3 = 4'd11,
    RegAttr4 = 4'd12,
    RegAttr5 = 4'd13,
    RegAttr6 = 4'd14,
    RegAttr7 = 4'd15
  } cfg_reg_e;

endpackage : pad_pkg
